//--- flist.f
common/spi_pkg.sv
common/display_pkg.sv
spi/spi_peripheral.sv
spi/spi_subperipheral_selector.sv
spi/spi_register_version_string.sv
display/display_mode_register.sv
display/display.sv
design/frame_top.sv
testbench/frame_top_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    -f flist.f --top-module frame_top_tb -Mdir obj_dir

output=$(./obj_dir/Vframe_top_tb)
echo "$output"

if grep -q "Everything OK" <<< "$output"; then
    exit 0
fi
exit 1

//--- testbench/frame_top_tb.sv
`timescale 1ns/1ps
// Directed testbench for frame_top that drives the SPI link and watches the display outputs
module frame_top_tb;

    // SPI half period and raster timing in clock cycles
    localparam int half_period = 8;
    localparam int line_cycles = 840;
    localparam int sync_cycles = 64;
    localparam int back_cycles = 120;
    localparam int frame_lines = 450;
    localparam int back_lines = 39;
    localparam int frame_cycles = line_cycles * frame_lines;
    localparam logic [31:0] lfsr_taps = 32'h8020_0003;

    logic clock_50MHz;
    logic reset;
    logic spi_select;
    logic spi_clock;
    logic spi_copi;
    logic spi_cipo;
    logic hsync;
    logic vsync;
    logic [3:0] luma;
    logic [2:0] chroma_r;
    logic [2:0] chroma_b;

    logic [7:0] tx_bytes[8];
    logic [7:0] rx_bytes[8];
    logic [31:0] lfsr_state = 32'h0317_0d82;
    logic timed_out = 1'b0;
    int error_count = 0;
    int tests_run = 0;
    int tests_failed = 0;

    // "v1.0" then the zero padding past the end of the text
    logic [7:0] version_chars[6] = '{8'h76, 8'h31, 8'h2E, 8'h30, 8'h00, 8'h00};
    int sample_columns[11] = '{0, 45, 80, 239, 320, 400, 479, 560, 639, 640, 700};

    frame_top frame_top_inst (
        .clock_50MHz(clock_50MHz),
        .reset(reset),
        .spi_select(spi_select),
        .spi_clock(spi_clock),
        .spi_copi(spi_copi),
        .spi_cipo(spi_cipo),
        .hsync(hsync),
        .vsync(vsync),
        .luma(luma),
        .chroma_r(chroma_r),
        .chroma_b(chroma_b)
    );

    initial begin
        clock_50MHz = 1'b0;
        forever #10 clock_50MHz = ~clock_50MHz;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ lfsr_taps;
        end
        return state >> 1;
    endfunction

    task automatic random_bits(input int count, output logic [7:0] bits);
        bits = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits = {bits[6:0], lfsr_state[0]};
        end
    endtask

    // Packed as luma, chroma_r, chroma_b
    function automatic logic [9:0] expected_pixel(input logic [7:0] mode_byte, input int column);
        int bar;
        int step;
        bar = column / 80;
        step = column / 40;
        if (column >= 640) begin
            return 10'd0;
        end
        if (mode_byte == 8'd1) begin
            return {4'(2 * bar), 3'(bar), 3'(7 - bar)};
        end
        if (mode_byte == 8'd2) begin
            return {4'(step > 15 ? 15 : step), 3'd4, 3'd4};
        end
        return 10'd0;
    endfunction

    task automatic wait_cycles(input int count);
        repeat (count) @(posedge clock_50MHz);
    endtask

    task automatic check_equal(input string signal, input int expected, input int actual);
        assert (actual == expected) else begin
            $display("Mismatch at %0t: %s expected 0x%0h, got 0x%0h",
                     $time, signal, expected, actual);
            error_count++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (error_count == errors_before) begin
            $display("%s: passed", name);
        end else begin
            tests_failed++;
            $display("%s: FAILED", name);
        end
    endtask

    // Full transaction, data sampled on cipo just before each rising edge
    task automatic spi_transfer(input int count);
        logic [7:0] received;
        @(posedge clock_50MHz);
        spi_select <= 1'b0;
        for (int i = 0; i < count; i++) begin
            for (int b = 7; b >= 0; b--) begin
                spi_copi <= tx_bytes[i][b];
                wait_cycles(half_period);
                @(negedge clock_50MHz);
                received = {received[6:0], spi_cipo};
                @(posedge clock_50MHz);
                spi_clock <= 1'b1;
                wait_cycles(half_period);
                spi_clock <= 1'b0;
            end
            rx_bytes[i] = received;
        end
        wait_cycles(half_period);
        spi_select <= 1'b1;
        wait_cycles(2 * half_period);
    endtask

    task automatic write_mode(input logic [7:0] value);
        tx_bytes[0] = 8'h30;
        tx_bytes[1] = value;
        spi_transfer(2);
    endtask

    // Returns at the first falling clock edge where the sync output shows level
    task automatic wait_sync(input logic vertical, input logic level, input int limit,
                             output int waited);
        logic value;
        waited = 0;
        value = ~level;
        while (value != level && !timed_out) begin
            @(negedge clock_50MHz);
            value = vertical ? vsync : hsync;
            if (value != level) begin
                waited++;
                if (waited > limit) begin
                    timed_out = 1'b1;
                    error_count++;
                    $display("Timeout at %0t: %s never reached %b within %0d cycles",
                             $time, vertical ? "vsync" : "hsync", level, limit);
                end
            end
        end
    endtask

    task automatic read_chip_identity();
        int errors_before;
        errors_before = error_count;
        tx_bytes[0] = 8'hDB;
        tx_bytes[1] = 8'h00;
        spi_transfer(2);
        check_equal("spi_cipo byte 2", 8'h81, int'(rx_bytes[1]));
        report_test("chip identity", errors_before);
    endtask

    task automatic read_version_string();
        int errors_before;
        errors_before = error_count;
        tx_bytes[0] = 8'hB5;
        for (int i = 1; i < 7; i++) begin
            tx_bytes[i] = 8'h00;
        end
        spi_transfer(7);
        for (int i = 0; i < 6; i++) begin
            check_equal($sformatf("spi_cipo byte %0d", i + 2), int'(version_chars[i]),
                        int'(rx_bytes[i + 1]));
        end
        report_test("version string", errors_before);
    endtask

    task automatic probe_unknown_address();
        int errors_before;
        errors_before = error_count;
        tx_bytes[0] = 8'h42;
        tx_bytes[1] = 8'h00;
        spi_transfer(2);
        check_equal("spi_cipo byte 2", 8'hFF, int'(rx_bytes[1]));
        report_test("unknown address", errors_before);
    endtask

    // Read back repeats the same byte so the stored mode stays put
    task automatic write_and_read_mode();
        int errors_before;
        logic [7:0] value;
        logic [7:0] encoding;
        logic [7:0] previous;
        errors_before = error_count;
        previous = 8'd0;
        for (int round = 0; round < 4; round++) begin
            random_bits(2, value);
            encoding = (value == 8'd1 || value == 8'd2) ? value : 8'd0;
            write_mode(value);
            check_equal("mode reply before write", int'(previous), int'(rx_bytes[1]));
            write_mode(value);
            check_equal("mode read back", int'(encoding), int'(rx_bytes[1]));
            previous = encoding;
        end
        report_test("mode write and read", errors_before);
    endtask

    task automatic measure_sync_timing();
        int errors_before;
        int waited;
        int high_time;
        errors_before = error_count;
        wait_sync(1'b0, 1'b0, line_cycles + 2, waited);
        wait_sync(1'b0, 1'b1, line_cycles + 2, waited);
        wait_sync(1'b0, 1'b0, line_cycles + 2, waited);
        high_time = waited + 1;
        wait_sync(1'b0, 1'b1, line_cycles + 2, waited);
        check_equal("hsync high cycles", sync_cycles, high_time);
        check_equal("hsync period", line_cycles, high_time + waited + 1);
        wait_sync(1'b1, 1'b0, frame_cycles + 2, waited);
        wait_sync(1'b1, 1'b1, frame_cycles + 2, waited);
        wait_sync(1'b1, 1'b0, frame_cycles + 2, waited);
        high_time = waited + 1;
        wait_sync(1'b1, 1'b1, frame_cycles + 2, waited);
        check_equal("vsync period", frame_cycles, high_time + waited + 1);
        report_test("sync timing", errors_before);
    endtask

    // Pixels for column c appear c + h_back + 1 cycles after hsync falls
    task automatic inspect_picture(input logic [7:0] mode_byte, input string name);
        int errors_before;
        int waited;
        int offset;
        int column;
        logic [9:0] pixel;
        errors_before = error_count;
        write_mode(mode_byte);
        wait_sync(1'b1, 1'b1, frame_cycles + 2, waited);
        wait_sync(1'b1, 1'b0, frame_cycles + 2, waited);
        // Skip the back porch and land on active line 5
        for (int step = 0; step < back_lines + 5; step++) begin
            wait_sync(1'b0, 1'b1, line_cycles + 2, waited);
            wait_sync(1'b0, 1'b0, line_cycles + 2, waited);
        end
        offset = 0;
        for (int i = 0; i < 11; i++) begin
            column = sample_columns[i];
            while (offset < column + back_cycles + 1) begin
                @(negedge clock_50MHz);
                offset++;
            end
            pixel = expected_pixel(mode_byte, column);
            check_equal($sformatf("luma at column %0d", column), int'(pixel[9:6]), int'(luma));
            check_equal($sformatf("chroma_r at column %0d", column), int'(pixel[5:3]),
                        int'(chroma_r));
            check_equal($sformatf("chroma_b at column %0d", column), int'(pixel[2:0]),
                        int'(chroma_b));
        end
        report_test(name, errors_before);
    endtask

    initial begin
        reset = 1'b1;
        spi_select = 1'b1;
        spi_clock = 1'b0;
        spi_copi = 1'b0;
        wait_cycles(2);
        reset <= 1'b0;
        wait_cycles(4);

        read_chip_identity();
        read_version_string();
        probe_unknown_address();
        write_and_read_mode();
        measure_sync_timing();
        inspect_picture(8'd1, "colour bars picture");
        inspect_picture(8'd0, "blank picture");
        inspect_picture(8'd2, "luma ramp picture");

        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- design/frame_top.sv
`timescale 1ns/1ps
// Top level joining the SPI control path to the display generator
module frame_top (
    input logic clock_50MHz,
    input logic reset,

    input logic spi_select,
    input logic spi_clock,
    input logic spi_copi,
    output logic spi_cipo,

    output logic hsync,
    output logic vsync,
    output display_pkg::luma_t luma,
    output display_pkg::chroma_t chroma_r,
    output display_pkg::chroma_t chroma_b
);
    import spi_pkg::*;
    import display_pkg::*;

    spi_address_t address;
    logic address_valid;
    spi_byte_t copi_data;
    logic copi_valid;
    logic transaction_end;
    spi_byte_t cipo_data;
    logic cipo_valid;

    logic version_enable;
    spi_byte_t version_data;
    logic version_valid;

    logic mode_enable;
    spi_byte_t mode_data;
    logic mode_valid;
    display_mode_t mode;

    spi_peripheral spi_peripheral_inst (
        .clock_50MHz(clock_50MHz),
        .reset(reset),
        .spi_select(spi_select),
        .spi_clock(spi_clock),
        .spi_copi(spi_copi),
        .spi_cipo(spi_cipo),
        .address(address),
        .address_valid(address_valid),
        .copi_data(copi_data),
        .copi_valid(copi_valid),
        .transaction_end(transaction_end),
        .cipo_data(cipo_data),
        .cipo_valid(cipo_valid)
    );

    spi_subperipheral_selector spi_subperipheral_selector_inst (
        .clock_50MHz(clock_50MHz),
        .reset(reset),
        .address(address),
        .address_valid(address_valid),
        .transaction_end(transaction_end),
        .version_enable(version_enable),
        .mode_enable(mode_enable),
        .version_data(version_data),
        .version_valid(version_valid),
        .mode_data(mode_data),
        .mode_valid(mode_valid),
        .cipo_data(cipo_data),
        .cipo_valid(cipo_valid)
    );

    spi_register_version_string spi_register_version_string_inst (
        .clock_50MHz(clock_50MHz),
        .reset(reset),
        .enable(version_enable),
        .copi_valid(copi_valid),
        .reply_data(version_data),
        .reply_valid(version_valid)
    );

    display_mode_register display_mode_register_inst (
        .clock_50MHz(clock_50MHz),
        .reset(reset),
        .enable(mode_enable),
        .copi_data(copi_data),
        .copi_valid(copi_valid),
        .reply_data(mode_data),
        .reply_valid(mode_valid),
        .mode(mode)
    );

    display display_inst (
        .clock_50MHz(clock_50MHz),
        .reset(reset),
        .mode(mode),
        .hsync(hsync),
        .vsync(vsync),
        .luma(luma),
        .chroma_r(chroma_r),
        .chroma_b(chroma_b)
    );

endmodule

//--- display/display.sv
`timescale 1ns/1ps
// Raster timing generator and test picture source for the display outputs
module display (
    input logic clock_50MHz,
    input logic reset,
    input display_pkg::display_mode_t mode,
    output logic hsync,
    output logic vsync,
    output display_pkg::luma_t luma,
    output display_pkg::chroma_t chroma_r,
    output display_pkg::chroma_t chroma_b
);
    import display_pkg::*;

    coord_t column;
    coord_t row;
    logic active;
    logic [2:0] bar_index;
    coord_t ramp_step;

    luma_t next_luma;
    chroma_t next_chroma_r;
    chroma_t next_chroma_b;

    always_ff @(posedge clock_50MHz) begin
        if (reset) begin
            column <= '0;
            row <= '0;
        end else if (column == coord_t'(h_total - 1)) begin
            column <= '0;
            row <= (row == coord_t'(v_total - 1)) ? '0 : row + coord_t'(1);
        end else begin
            column <= column + coord_t'(1);
        end
    end

    // Sync pulses follow the front porch
    assign hsync = column >= coord_t'(h_active + h_front)
                   && column < coord_t'(h_active + h_front + h_sync);
    assign vsync = row >= coord_t'(v_active + v_front)
                   && row < coord_t'(v_active + v_front + v_sync);

    assign active = column < coord_t'(h_active) && row < coord_t'(v_active);

    // Eight bars or sixteen ramp steps across the line
    assign bar_index = 3'(column / coord_t'(h_active / 8));
    assign ramp_step = column / coord_t'(h_active / 16);

    always_comb begin
        next_luma = '0;
        next_chroma_r = '0;
        next_chroma_b = '0;
        if (active) begin
            case (mode)
                colour_bars: begin
                    next_luma = {bar_index, 1'b0};
                    next_chroma_r = bar_index;
                    next_chroma_b = 3'd7 - bar_index;
                end
                luma_ramp: begin
                    next_luma = (ramp_step > coord_t'(15)) ? 4'd15 : luma_t'(ramp_step);
                    next_chroma_r = 3'd4;
                    next_chroma_b = 3'd4;
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clock_50MHz) begin
        luma <= next_luma;
        chroma_r <= next_chroma_r;
        chroma_b <= next_chroma_b;
    end

    column_in_range: assert property (@(posedge clock_50MHz) disable iff (reset)
        column < coord_t'(h_total));

endmodule

//--- display/display_mode_register.sv
`timescale 1ns/1ps
// SPI writable register holding the picture mode for the display generator
module display_mode_register (
    input logic clock_50MHz,
    input logic reset,
    input logic enable,
    input spi_pkg::spi_byte_t copi_data,
    input logic copi_valid,
    output spi_pkg::spi_byte_t reply_data,
    output logic reply_valid,
    output display_pkg::display_mode_t mode
);
    import spi_pkg::*;
    import display_pkg::*;

    logic enable_prev;
    // Set once the first data byte of the transaction has been taken
    logic written;

    always_ff @(posedge clock_50MHz) begin
        if (reset) begin
            enable_prev <= 1'b0;
            written <= 1'b0;
            reply_valid <= 1'b0;
            mode <= blank;
        end else begin
            enable_prev <= enable;
            reply_valid <= 1'b0;
            if (enable && !enable_prev) begin
                written <= 1'b0;
                reply_data <= spi_byte_t'(mode);
                reply_valid <= 1'b1;
            end else if (enable && copi_valid && !written) begin
                written <= 1'b1;
                case (copi_data)
                    8'd1: mode <= colour_bars;
                    8'd2: mode <= luma_ramp;
                    default: mode <= blank;
                endcase
            end
        end
    end

endmodule

//--- spi/spi_register_version_string.sv
`timescale 1ns/1ps
// Read-only SPI register that returns the version text one character per data byte
module spi_register_version_string (
    input logic clock_50MHz,
    input logic reset,
    input logic enable,
    input logic copi_valid,
    output spi_pkg::spi_byte_t reply_data,
    output logic reply_valid
);
    import spi_pkg::*;

    logic enable_prev;
    logic [2:0] index;
    logic [2:0] next_index;

    // Zero once the text has run out
    function automatic spi_byte_t character(input logic [2:0] position);
        if (position < 3'(version_length)) begin
            return version_text[31 - 8 * position -: 8];
        end
        return 8'h00;
    endfunction

    // Index parks at the end of the text
    assign next_index = (index == 3'(version_length)) ? index : index + 3'd1;

    always_ff @(posedge clock_50MHz) begin
        if (reset) begin
            enable_prev <= 1'b0;
            index <= '0;
            reply_valid <= 1'b0;
        end else begin
            enable_prev <= enable;
            reply_valid <= 1'b0;
            if (enable && !enable_prev) begin
                index <= '0;
                reply_data <= character(3'd0);
                reply_valid <= 1'b1;
            end else if (enable && copi_valid) begin
                index <= next_index;
                reply_data <= character(next_index);
                reply_valid <= 1'b1;
            end
        end
    end

endmodule

//--- spi/spi_subperipheral_selector.sv
`timescale 1ns/1ps
// Address decoder that enables one subperipheral per transaction and merges the reply bytes
module spi_subperipheral_selector (
    input logic clock_50MHz,
    input logic reset,
    input spi_pkg::spi_address_t address,
    input logic address_valid,
    input logic transaction_end,

    output logic version_enable,
    output logic mode_enable,
    input spi_pkg::spi_byte_t version_data,
    input logic version_valid,
    input spi_pkg::spi_byte_t mode_data,
    input logic mode_valid,

    output spi_pkg::spi_byte_t cipo_data,
    output logic cipo_valid
);
    import spi_pkg::*;

    // Reply answered here, chip identity or no device
    spi_byte_t fixed_data;
    logic fixed_valid;

    always_ff @(posedge clock_50MHz) begin
        if (reset) begin
            version_enable <= 1'b0;
            mode_enable <= 1'b0;
            fixed_valid <= 1'b0;
        end else begin
            fixed_valid <= 1'b0;
            if (address_valid) begin
                version_enable <= address == version_string_address;
                mode_enable <= address == display_mode_address;
                fixed_valid <= address != version_string_address
                               && address != display_mode_address;
                fixed_data <= (address == chip_id_address) ? chip_id_value : no_device_reply;
            end else if (transaction_end) begin
                version_enable <= 1'b0;
                mode_enable <= 1'b0;
            end
        end
    end

    always_comb begin
        cipo_data = no_device_reply;
        cipo_valid = 1'b0;
        if (fixed_valid) begin
            cipo_data = fixed_data;
            cipo_valid = 1'b1;
        end else if (version_enable) begin
            cipo_data = version_data;
            cipo_valid = version_valid;
        end else if (mode_enable) begin
            cipo_data = mode_data;
            cipo_valid = mode_valid;
        end
    end

    one_enable: assert property (@(posedge clock_50MHz) disable iff (reset)
        !(version_enable && mode_enable));

endmodule

//--- spi/spi_peripheral.sv
`timescale 1ns/1ps
// Mode 0 SPI peripheral that frames host bytes into strobes and shifts the latest reply back out
module spi_peripheral (
    input logic clock_50MHz,
    input logic reset,

    input logic spi_select,
    input logic spi_clock,
    input logic spi_copi,
    output logic spi_cipo,

    output spi_pkg::spi_address_t address,
    output logic address_valid,
    output spi_pkg::spi_byte_t copi_data,
    output logic copi_valid,
    output logic transaction_end,
    input spi_pkg::spi_byte_t cipo_data,
    input logic cipo_valid
);
    import spi_pkg::*;

    // Bit 1 is the synchronised pin, bit 2 its previous value
    logic [2:0] select_sync;
    logic [2:0] clock_sync;
    logic [1:0] copi_sync;

    logic selected;
    logic select_fall;
    logic select_rise;
    logic clock_rise;
    logic clock_fall;

    logic [2:0] bit_count;
    logic first_byte;
    spi_byte_t shift_in;
    spi_byte_t shift_out;
    spi_byte_t reply_latch;

    always_ff @(posedge clock_50MHz) begin
        if (reset) begin
            select_sync <= 3'b111;
            clock_sync <= '0;
            copi_sync <= '0;
        end else begin
            select_sync <= {select_sync[1:0], spi_select};
            clock_sync <= {clock_sync[1:0], spi_clock};
            copi_sync <= {copi_sync[0], spi_copi};
        end
    end

    assign selected = !select_sync[1];
    assign select_fall = !select_sync[1] && select_sync[2];
    assign select_rise = select_sync[1] && !select_sync[2];
    assign clock_rise = selected && clock_sync[1] && !clock_sync[2];
    assign clock_fall = selected && !clock_sync[1] && clock_sync[2];

    always_ff @(posedge clock_50MHz) begin
        if (reset) begin
            bit_count <= '0;
            first_byte <= 1'b1;
            address_valid <= 1'b0;
            copi_valid <= 1'b0;
            transaction_end <= 1'b0;
            shift_in <= '0;
            shift_out <= '0;
            reply_latch <= '0;
        end else begin
            address_valid <= 1'b0;
            copi_valid <= 1'b0;
            transaction_end <= select_rise;

            if (cipo_valid) begin
                reply_latch <= cipo_data;
            end

            // Leftover reply goes out during the address byte
            if (select_fall) begin
                bit_count <= '0;
                first_byte <= 1'b1;
                shift_out <= reply_latch;
            end

            if (clock_rise) begin
                shift_in <= {shift_in[6:0], copi_sync[1]};
                bit_count <= bit_count + 3'd1;
                if (bit_count == 3'd7) begin
                    first_byte <= 1'b0;
                    if (first_byte) begin
                        address <= {shift_in[6:0], copi_sync[1]};
                        address_valid <= 1'b1;
                    end else begin
                        copi_data <= {shift_in[6:0], copi_sync[1]};
                        copi_valid <= 1'b1;
                    end
                end
            end

            // Count back at zero means a byte boundary has just passed
            if (clock_fall) begin
                if (bit_count == 3'd0) begin
                    shift_out <= reply_latch;
                end else begin
                    shift_out <= {shift_out[6:0], 1'b0};
                end
            end
        end
    end

    assign spi_cipo = shift_out[7];

    strobes_exclusive: assert property (@(posedge clock_50MHz) disable iff (reset)
        !(address_valid && copi_valid));

endmodule

//--- common/display_pkg.sv
// Raster timing, pixel component types and picture modes, imported by the display side modules
package display_pkg;

    // Horizontal timing in clock cycles
    localparam int h_active = 640;
    localparam int h_front = 16;
    localparam int h_sync = 64;
    localparam int h_back = 120;
    localparam int h_total = h_active + h_front + h_sync + h_back;

    // Vertical timing in lines
    localparam int v_active = 400;
    localparam int v_front = 5;
    localparam int v_sync = 6;
    localparam int v_back = 39;
    localparam int v_total = v_active + v_front + v_sync + v_back;

    // Column or line count, wide enough for h_total
    typedef logic [10:0] coord_t;
    typedef logic [3:0] luma_t;
    typedef logic [2:0] chroma_t;

    // Picture chosen by the host, anything unknown shows as blank
    typedef enum logic [1:0] {
        blank = 2'd0,
        colour_bars = 2'd1,
        luma_ramp = 2'd2
    } display_mode_t;

endpackage

//--- common/spi_pkg.sv
// SPI link types, register address map and fixed reply values, imported by the SPI side modules
package spi_pkg;

    // One byte on the link and one subperipheral address
    typedef logic [7:0] spi_byte_t;
    typedef logic [7:0] spi_address_t;

    // Register address map
    localparam spi_address_t chip_id_address = 8'hDB;
    localparam spi_address_t version_string_address = 8'hB5;
    localparam spi_address_t display_mode_address = 8'h30;

    // Identity answered directly by the selector
    localparam spi_byte_t chip_id_value = 8'h81;

    // Version text, first character in the top byte
    localparam int version_length = 4;
    localparam logic [31:0] version_text = "v1.0";

    // Reply when nothing sits at the address
    localparam spi_byte_t no_device_reply = 8'hFF;

endpackage
